// File: sd_card_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the spi-mode sd card
// command opcodes, r1 reply codes, tokens
// and the read and write fsm state enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sd_card_pkg;

	// opcodes as seen on the wire, start and transmission bits included
	typedef enum logic [7:0] {
		cmd_go_idle      = 8'h40,
		cmd_send_if_cond = 8'h48,
		cmd_set_blocklen = 8'h50,
		cmd_read_single  = 8'h51,
		cmd_write_block  = 8'h58,
		cmd_app_op_cond  = 8'h69,
		cmd_app          = 8'h77,
		cmd_read_ocr     = 8'h7a
	} sd_cmd_e;

	// single block read sequencing
	typedef enum logic [1:0] {
		rd_idle,
		rd_wait_io,
		rd_send_token,
		rd_send_data
	} rd_state_e;

	// single block write sequencing
	typedef enum logic [2:0] {
		wr_idle,
		wr_exp_token,
		wr_recv_data,
		wr_recv_crc0,
		wr_recv_crc1,
		wr_send_dresp,
		wr_busy
	} wr_state_e;

	// r1 reply bytes
	localparam logic [7:0] r1_ok        = 8'h00;
	localparam logic [7:0] r1_idle      = 8'h01;
	localparam logic [7:0] r1_illegal   = 8'h04;
	localparam logic [7:0] r1_param_err = 8'h40;

	// start block token and accepted data response
	localparam logic [7:0] data_token   = 8'hfe;
	localparam logic [7:0] data_resp_ok = 8'h05;

	localparam int sector_bytes    = 512;
	localparam int cmd_frame_bytes = 6;

endpackage

// File: sd_byte_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi byte stream between the pin link
// and the command decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface sd_byte_if;
	// received side
	logic       rx_valid;
	logic [7:0] rx_byte;
	// transmit side, tx_byte sampled in the tx_next cycle
	logic       tx_next;
	logic [7:0] tx_byte;
	// write busy, holds sdo at zero
	logic       busy_low;
	// cs went inactive
	logic       frame_reset;

	modport link (
		output rx_valid, rx_byte, tx_next, frame_reset,
		input  tx_byte, busy_low
	);

	modport decoder (
		input  rx_valid, rx_byte, tx_next, frame_reset,
		output tx_byte, busy_low
	);
endinterface

// File: sd_buf_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi side port of the sector buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface sd_buf_if;
	// zero both pointers
	logic       clear;
	// push one received byte at the write pointer
	logic       wr_en;
	logic [7:0] wr_byte;
	// step the read pointer
	logic       rd_next;
	logic [7:0] rd_byte;

	modport spi (
		output clear, wr_en, wr_byte, rd_next,
		input  rd_byte
	);

	modport mem (
		input  clear, wr_en, wr_byte, rd_next,
		output rd_byte
	);
endinterface

// File: sd_spi_link.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi mode 0 pin link
// pin synchronizers, sck edge detect,
// byte receive and transmit shifters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_spi_link (
	input  logic    buffer_dout_strobe,
	input  logic    io_ack,
	input  logic    sd_cs,
	input  logic    sd_sck,
	input  logic    sd_sdi,
	output logic    sd_sdo,
	sd_byte_if.link bytes
);
	logic [1:0] cs_s;
	logic [1:0] sck_s;
	logic [1:0] sdi_s;
	logic       cs_d;
	logic       sck_d;
	logic       sck_rise;
	logic       sck_fall;
	logic [2:0] bit_cnt;
	logic [6:0] rx_sr;
	logic [7:0] tx_sr;

	// edges only count while the card is selected
	assign sck_rise = sck_s[1] & ~sck_d & ~cs_s[1];
	assign sck_fall = ~sck_s[1] & sck_d & ~cs_s[1];
	// first falling edge of a byte asks for the next tx byte
	assign bytes.tx_next = sck_fall & (bit_cnt == 3'd0);

	// two stage synchronizers, sdi stays aligned with sck
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			cs_s  <= 2'b11;
			sck_s <= 2'b00;
			sdi_s <= 2'b11;
			cs_d  <= 1'b1;
			sck_d <= 1'b0;
		end else begin
			cs_s  <= {cs_s[0], sd_cs};
			sck_s <= {sck_s[0], sd_sck};
			sdi_s <= {sdi_s[0], sd_sdi};
			cs_d  <= cs_s[1];
			sck_d <= sck_s[1];
		end
	end

	// receiver, msb first
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			bit_cnt           <= 3'd0;
			rx_sr             <= 7'd0;
			bytes.rx_byte     <= 8'd0;
			bytes.rx_valid    <= 1'b0;
			bytes.frame_reset <= 1'b0;
		end else begin
			bytes.rx_valid    <= 1'b0;
			bytes.frame_reset <= cs_s[1] & ~cs_d;
			if (cs_s[1]) begin
				bit_cnt <= 3'd0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				rx_sr   <= {rx_sr[5:0], sdi_s[1]};
				if (bit_cnt == 3'd7) begin
					bytes.rx_byte  <= {rx_sr, sdi_s[1]};
					bytes.rx_valid <= 1'b1;
				end
			end
		end
	end

	// transmitter, bit 7 leaves with the load and ones fill in behind
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			tx_sr  <= 8'hff;
			sd_sdo <= 1'b1;
		end else if (cs_s[1]) begin
			tx_sr  <= 8'hff;
			sd_sdo <= 1'b1;
		end else if (bytes.tx_next) begin
			tx_sr  <= bytes.busy_low ? 8'h00 : bytes.tx_byte;
			sd_sdo <= bytes.tx_byte[7] & ~bytes.busy_low;
		end else if (sck_fall) begin
			tx_sr  <= {tx_sr[6:0], 1'b1};
			sd_sdo <= tx_sr[6];
		end
	end

endmodule

// File: sd_cmd_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command frame parser and r1/r3/r7 replies
// single block read and write fsms
// sector request handshake toward the controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_cmd_decoder
	import sd_card_pkg::*;
#(
	parameter int ncr = 2
) (
	input  logic          buffer_dout_strobe,
	input  logic          io_ack,
	sd_byte_if.decoder    bytes,
	sd_buf_if.spi         buf_port,
	input  logic          io_sdhc,
	input  logic          sector_ack,
	output logic          sector_rd,
	output logic          sector_wr,
	output logic [31:0]   cmd_arg
);
	localparam int cw = $clog2(ncr + 6);
	localparam int dw = $clog2(sector_bytes);

	sd_cmd_e        cmd;
	rd_state_e      rd_state;
	wr_state_e      wr_state;
	logic           in_frame;
	logic [2:0]     fcnt;
	logic           card_reset;
	logic           cmd55;
	logic           rsp_active;
	logic [cw-1:0]  rsp_cnt;
	logic [cw-1:0]  rsp_last;
	logic [7:0]     reply;
	logic [31:0]    reply_ext;
	logic           has_ext;
	logic [7:0]     rep_code;
	logic [31:0]    rep_ext;
	logic           rep_has_ext;
	logic [dw-1:0]  dcnt;
	logic           ack_d;
	logic           ack_seen;
	logic           wr_done;
	logic           frame_start;
	logic           frame_end;
	logic           slot;
	logic           ack_rise;
	logic           ack_fall;

	// a new frame needs 01 in front and both fsms idle
	assign frame_start = bytes.rx_valid & ~in_frame & (bytes.rx_byte[7:6] == 2'b01)
		& (rd_state == rd_idle) & (wr_state == wr_idle);
	assign frame_end = bytes.rx_valid & in_frame & (fcnt == 3'(cmd_frame_bytes - 1));
	// data phase byte slots, the reply owns the line first
	assign slot = bytes.tx_next & ~rsp_active;
	assign rsp_last = cw'(ncr) + (has_ext ? cw'(4) : cw'(0));
	assign ack_rise = sector_ack & ~ack_d;
	assign ack_fall = ~sector_ack & ack_d;

	assign buf_port.clear   = frame_start;
	assign buf_port.wr_en   = bytes.rx_valid & (wr_state == wr_recv_data);
	assign buf_port.wr_byte = bytes.rx_byte;
	assign buf_port.rd_next = slot & (rd_state == rd_send_data);
	// zeros until the first slot after the controller drops ack
	assign bytes.busy_low   = (wr_state == wr_busy) & ~wr_done;

	// reply selection, every command except cmd0 needs a reset card
	always_comb begin
		rep_code    = r1_illegal;
		rep_ext     = 32'd0;
		rep_has_ext = 1'b0;
		if (cmd == cmd_go_idle) begin
			rep_code = r1_idle;
		end else if (card_reset) begin
			case (cmd)
				cmd_send_if_cond: begin
					// r7 echoes voltage and check pattern
					rep_code    = r1_idle;
					rep_ext     = {20'd0, cmd_arg[11:0]};
					rep_has_ext = 1'b1;
				end
				cmd_set_blocklen:
					rep_code = (cmd_arg == 32'(sector_bytes)) ? r1_ok : r1_param_err;
				cmd_read_single, cmd_write_block:
					rep_code = r1_ok;
				cmd_app:
					rep_code = r1_idle;
				cmd_app_op_cond:
					rep_code = cmd55 ? r1_ok : r1_illegal;
				cmd_read_ocr: begin
					// ocr bit 30 is the ccs flag
					rep_code    = r1_ok;
					rep_ext     = {1'b0, io_sdhc, 30'd0};
					rep_has_ext = 1'b1;
				end
				default:
					rep_code = r1_illegal;
			endcase
		end
	end

	// byte for the current slot, 0xff when nothing is due
	always_comb begin
		bytes.tx_byte = 8'hff;
		if (rsp_active) begin
			if (rsp_cnt == cw'(ncr))
				bytes.tx_byte = reply;
			else if (rsp_cnt > cw'(ncr))
				bytes.tx_byte = reply_ext[31:24];
		end else if (rd_state == rd_send_token) begin
			bytes.tx_byte = data_token;
		end else if (rd_state == rd_send_data) begin
			bytes.tx_byte = buf_port.rd_byte;
		end else if (wr_state == wr_send_dresp) begin
			bytes.tx_byte = data_resp_ok;
		end
	end

	// frame capture and reply sequencing
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			in_frame   <= 1'b0;
			fcnt       <= 3'd0;
			cmd        <= cmd_go_idle;
			cmd_arg    <= 32'd0;
			cmd55      <= 1'b0;
			card_reset <= 1'b0;
			rsp_active <= 1'b0;
			rsp_cnt    <= '0;
			reply      <= 8'hff;
			reply_ext  <= 32'd0;
			has_ext    <= 1'b0;
		end else begin
			if (bytes.tx_next && rsp_active) begin
				if (rsp_cnt > cw'(ncr))
					reply_ext <= {reply_ext[23:0], 8'hff};
				if (rsp_cnt == rsp_last)
					rsp_active <= 1'b0;
				else
					rsp_cnt <= rsp_cnt + 1'b1;
			end
			if (frame_start) begin
				in_frame <= 1'b1;
				fcnt     <= 3'd1;
				cmd      <= sd_cmd_e'(bytes.rx_byte);
				// previous opcode decides the app prefix
				cmd55    <= (cmd == cmd_app);
			end else if (bytes.rx_valid && in_frame) begin
				fcnt <= fcnt + 3'd1;
				// argument bytes 1 to 4, crc byte ignored
				if (fcnt < 3'(cmd_frame_bytes - 1))
					cmd_arg <= {cmd_arg[23:0], bytes.rx_byte};
				if (frame_end) begin
					in_frame   <= 1'b0;
					rsp_active <= 1'b1;
					rsp_cnt    <= '0;
					reply      <= rep_code;
					reply_ext  <= rep_ext;
					has_ext    <= rep_has_ext;
					if (cmd == cmd_go_idle)
						card_reset <= 1'b1;
				end
			end
			if (bytes.frame_reset) begin
				in_frame   <= 1'b0;
				rsp_active <= 1'b0;
			end
		end
	end

	// read and write fsms, sector requests
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			rd_state  <= rd_idle;
			wr_state  <= wr_idle;
			sector_rd <= 1'b0;
			sector_wr <= 1'b0;
			ack_d     <= 1'b0;
			ack_seen  <= 1'b0;
			wr_done   <= 1'b0;
			dcnt      <= '0;
		end else begin
			ack_d <= sector_ack;
			// controller took the request
			if (ack_rise) begin
				ack_seen  <= 1'b1;
				sector_rd <= 1'b0;
				sector_wr <= 1'b0;
			end
			case (rd_state)
				rd_idle:
					if (frame_end && card_reset && cmd == cmd_read_single) begin
						rd_state  <= rd_wait_io;
						sector_rd <= 1'b1;
						ack_seen  <= 1'b0;
					end
				rd_wait_io:
					// falling ack means the sector sits in the buffer
					if (ack_seen && ack_fall)
						rd_state <= rd_send_token;
				rd_send_token:
					if (slot) begin
						rd_state <= rd_send_data;
						dcnt     <= '0;
					end
				rd_send_data:
					if (slot) begin
						dcnt <= dcnt + 1'b1;
						if (dcnt == dw'(sector_bytes - 1))
							rd_state <= rd_idle;
					end
			endcase
			case (wr_state)
				wr_idle:
					if (frame_end && card_reset && cmd == cmd_write_block)
						wr_state <= wr_exp_token;
				wr_exp_token:
					if (bytes.rx_valid && bytes.rx_byte == data_token) begin
						wr_state <= wr_recv_data;
						dcnt     <= '0;
					end
				wr_recv_data:
					if (bytes.rx_valid) begin
						dcnt <= dcnt + 1'b1;
						if (dcnt == dw'(sector_bytes - 1))
							wr_state <= wr_recv_crc0;
					end
				wr_recv_crc0:
					if (bytes.rx_valid)
						wr_state <= wr_recv_crc1;
				wr_recv_crc1:
					if (bytes.rx_valid)
						wr_state <= wr_send_dresp;
				wr_send_dresp:
					// response goes out in this slot, then ask the controller
					if (slot) begin
						wr_state  <= wr_busy;
						sector_wr <= 1'b1;
						ack_seen  <= 1'b0;
						wr_done   <= 1'b0;
					end
				wr_busy: begin
					if (ack_seen && ack_fall)
						wr_done <= 1'b1;
					if (bytes.tx_next && wr_done)
						wr_state <= wr_idle;
				end
				default:
					wr_state <= wr_idle;
			endcase
		end
	end

endmodule

// File: sd_sector_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512 byte sector memory, shared pointers
// and the configuration byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_sector_buffer
	import sd_card_pkg::*;
(
	input  logic       buffer_dout_strobe,
	input  logic       io_ack,
	sd_buf_if.mem      buf_port,
	input  logic [7:0] sector_din,
	input  logic       sector_din_strobe,
	output logic [7:0] sector_dout,
	input  logic       sector_dout_strobe,
	input  logic       sector_ack,
	output logic       io_conf,
	output logic       conf_sdhc
);
	localparam int aw = $clog2(sector_bytes);

	logic [7:0]    mem [sector_bytes];
	logic [aw-1:0] wptr;
	logic [aw-1:0] rptr;
	logic          push;
	logic [7:0]    push_byte;
	logic          conf_wr;
	logic          conf_done;
	logic          conf;

	// controller bytes land in the sector only inside an ack window
	assign push      = buf_port.wr_en | (sector_din_strobe & sector_ack);
	assign push_byte = buf_port.wr_en ? buf_port.wr_byte : sector_din;
	// outside ack the first byte is the configuration
	assign conf_wr   = sector_din_strobe & ~sector_ack & ~conf_done;

	always_ff @(posedge buffer_dout_strobe) begin
		if (push)
			mem[wptr] <= push_byte;
	end

	// both sides step the same pointers
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			wptr <= '0;
			rptr <= '0;
		end else if (buf_port.clear) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push)
				wptr <= wptr + 1'b1;
			if (buf_port.rd_next || sector_dout_strobe)
				rptr <= rptr + 1'b1;
		end
	end

	// only the sdhc bit of the configuration byte is kept
	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			conf_done <= 1'b0;
			conf      <= 1'b0;
		end else if (conf_wr) begin
			conf_done <= 1'b1;
			conf      <= sector_din[0];
		end
	end

	// current byte is visible before any strobe
	assign buf_port.rd_byte = mem[rptr];
	assign sector_dout      = mem[rptr];
	assign io_conf          = ~conf_done;
	// bit 0 set when the controller's own card is sdhc
	assign conf_sdhc        = conf;

endmodule

// File: sd_card_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi-mode sd card emulation top level
// link, decoder and sector buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_card_top #(
	parameter int ncr = 2
) (
	input  logic        buffer_dout_strobe,
	input  logic        io_ack,
	input  logic        sd_cs,
	input  logic        sd_sck,
	input  logic        sd_sdi,
	output logic        sd_sdo,
	output logic [31:0] io_lba,
	output logic        sector_rd,
	output logic        sector_wr,
	input  logic        sector_ack,
	input  logic [7:0]  sector_din,
	input  logic        sector_din_strobe,
	output logic [7:0]  sector_dout,
	input  logic        sector_dout_strobe,
	input  logic        allow_sdhc,
	output logic        io_conf,
	output logic        io_sdhc
);
	sd_byte_if bytes ();
	sd_buf_if  buf_port ();

	logic [31:0] cmd_arg;
	logic        conf_sdhc;

	assign io_sdhc = allow_sdhc & conf_sdhc;
	// sdsc cards address in bytes, convert to sectors
	assign io_lba  = io_sdhc ? cmd_arg : {9'd0, cmd_arg[31:9]};

	sd_spi_link u_link (
		.buffer_dout_strobe (buffer_dout_strobe),
		.io_ack             (io_ack),
		.sd_cs              (sd_cs),
		.sd_sck             (sd_sck),
		.sd_sdi             (sd_sdi),
		.sd_sdo             (sd_sdo),
		.bytes              (bytes.link)
	);

	sd_cmd_decoder #(
		.ncr (ncr)
	) u_decoder (
		.buffer_dout_strobe (buffer_dout_strobe),
		.io_ack             (io_ack),
		.bytes              (bytes.decoder),
		.buf_port           (buf_port.spi),
		.io_sdhc            (io_sdhc),
		.sector_ack         (sector_ack),
		.sector_rd          (sector_rd),
		.sector_wr          (sector_wr),
		.cmd_arg            (cmd_arg)
	);

	sd_sector_buffer u_buffer (
		.buffer_dout_strobe (buffer_dout_strobe),
		.io_ack             (io_ack),
		.buf_port           (buf_port.mem),
		.sector_din         (sector_din),
		.sector_din_strobe  (sector_din_strobe),
		.sector_dout        (sector_dout),
		.sector_dout_strobe (sector_dout_strobe),
		.sector_ack         (sector_ack),
		.io_conf            (io_conf),
		.conf_sdhc          (conf_sdhc)
	);

endmodule

// File: sd_card_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on the top level
// sector handshake and reset behaviour
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sd_card_chk (
	input logic buffer_dout_strobe,
	input logic io_ack,
	input logic sector_rd,
	input logic sector_wr,
	input logic sector_ack,
	input logic sd_sdo
);
	// one sector request at a time
	a_req_excl: assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		!(sector_rd && sector_wr))
		else $error("sector_rd and sector_wr high together");

	// requests drop only once the controller has acked
	a_rd_fall: assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		$fell(sector_rd) |-> sector_ack)
		else $error("sector_rd fell without sector_ack");

	a_wr_fall: assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		$fell(sector_wr) |-> sector_ack)
		else $error("sector_wr fell without sector_ack");

	// idle line level while held in reset
	a_sdo_reset: assert property (@(posedge buffer_dout_strobe) io_ack |-> sd_sdo)
		else $error("sd_sdo not high during reset");

endmodule

bind sd_card_top sd_card_chk u_chk (
	.buffer_dout_strobe (buffer_dout_strobe),
	.io_ack             (io_ack),
	.sector_rd          (sector_rd),
	.sector_wr          (sector_wr),
	.sector_ack         (sector_ack),
	.sd_sdo             (sd_sdo)
);

// File: tb_sd_card.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the spi-mode sd card
// spi host, controller and sector model,
// command sequence and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_sd_card;
	import sd_card_pkg::*;

	// about 3300 spi bytes at 104 clocks each, plus controller delays
	localparam int cycle_limit = 400000;

	logic        buffer_dout_strobe;
	logic        io_ack;
	logic        sd_cs;
	logic        sd_sck;
	logic        sd_sdi;
	logic        sd_sdo;
	logic [31:0] io_lba;
	logic        sector_rd;
	logic        sector_wr;
	logic        sector_ack;
	logic [7:0]  sector_din;
	logic        sector_din_strobe;
	logic [7:0]  sector_dout;
	logic        sector_dout_strobe;
	logic        allow_sdhc;
	logic        io_conf;
	logic        io_sdhc;

	int          cycles;
	logic [31:0] ctrl_lba;
	logic [7:0]  sent [sector_bytes];
	logic [7:0]  got [sector_bytes];
	// sector model keyed by lba and byte offset
	logic [7:0]  sector_model [logic [40:0]];

	sd_card_top UUT (.*);

	always #4 buffer_dout_strobe = ~buffer_dout_strobe;

	always @(posedge buffer_dout_strobe) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run went past its cycle limit");
			$display("Test FAILED");
			$fatal(1);
		end
	end

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail at %0t ns: %s expected %h got %h", $time, what, exp, act);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [7:0] model_byte(input logic [31:0] lba, input int idx);
		logic [40:0] key;
		key = {lba, idx[8:0]};
		if (!sector_model.exists(key))
			sector_model[key] = 8'($urandom);
		return sector_model[key];
	endfunction

	// spi mode 0, six clocks per half period, sdo sampled before the rising edge
	task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--) begin
			@(posedge buffer_dout_strobe);
			sd_sdi <= tx[i];
			repeat (5) @(posedge buffer_dout_strobe);
			@(negedge buffer_dout_strobe);
			rx[i] = sd_sdo;
			@(posedge buffer_dout_strobe);
			sd_sck <= 1'b1;
			repeat (6) @(posedge buffer_dout_strobe);
			sd_sck <= 1'b0;
		end
	endtask

	// clock 0xff until the line carries something else
	task automatic wait_byte(output logic [7:0] rx);
		do
			spi_xfer(8'hff, rx);
		while (rx == 8'hff);
	endtask

	task automatic send_cmd(input logic [7:0] op, input logic [31:0] arg, output logic [7:0] r1);
		logic [7:0] dummy;
		spi_xfer(op, dummy);
		for (int i = 3; i >= 0; i--)
			spi_xfer(arg[i*8 +: 8], dummy);
		// crc is not checked by the card
		spi_xfer(8'h95, dummy);
		wait_byte(r1);
	endtask

	task automatic read_ext(output logic [31:0] ext);
		logic [7:0] b;
		for (int i = 0; i < 4; i++) begin
			spi_xfer(8'hff, b);
			ext = {ext[23:0], b};
		end
	endtask

	// controller side, served from the sector model
	task automatic serve_read();
		ctrl_lba = io_lba;
		repeat ($urandom_range(5, 60)) @(posedge buffer_dout_strobe);
		sector_ack <= 1'b1;
		for (int i = 0; i < sector_bytes; i++) begin
			@(posedge buffer_dout_strobe);
			sector_din        <= model_byte(ctrl_lba, i);
			sector_din_strobe <= 1'b1;
			@(posedge buffer_dout_strobe);
			sector_din_strobe <= 1'b0;
		end
		@(posedge buffer_dout_strobe);
		sector_ack <= 1'b0;
	endtask

	task automatic serve_write();
		logic [40:0] key;
		ctrl_lba = io_lba;
		repeat ($urandom_range(5, 60)) @(posedge buffer_dout_strobe);
		sector_ack <= 1'b1;
		@(posedge buffer_dout_strobe);
		for (int i = 0; i < sector_bytes; i++) begin
			@(negedge buffer_dout_strobe);
			got[i] = sector_dout;
			key = {ctrl_lba, i[8:0]};
			sector_model[key] = sector_dout;
			@(posedge buffer_dout_strobe);
			sector_dout_strobe <= 1'b1;
			@(posedge buffer_dout_strobe);
			sector_dout_strobe <= 1'b0;
		end
		@(posedge buffer_dout_strobe);
		sector_ack <= 1'b0;
	endtask

	initial begin
		@(negedge io_ack);
		forever begin
			@(negedge buffer_dout_strobe);
			if (sector_rd)
				serve_read();
			else if (sector_wr)
				serve_write();
		end
	end

	// read one block and compare against the expected bytes
	task automatic read_block(input logic [31:0] arg, input logic [31:0] exp_lba,
			input logic from_sent);
		logic [7:0] b;
		send_cmd(cmd_read_single, arg, b);
		check("cmd17 reply", r1_ok, b);
		wait_byte(b);
		check("read token", data_token, b);
		check("read lba", exp_lba, ctrl_lba);
		for (int i = 0; i < sector_bytes; i++) begin
			spi_xfer(8'hff, b);
			check("read data", from_sent ? sent[i] : model_byte(exp_lba, i), b);
		end
	endtask

	task automatic write_block(input logic [31:0] arg, input logic [31:0] exp_lba);
		logic [7:0] b;
		send_cmd(cmd_write_block, arg, b);
		check("cmd24 reply", r1_ok, b);
		spi_xfer(data_token, b);
		for (int i = 0; i < sector_bytes; i++) begin
			sent[i] = 8'($urandom);
			spi_xfer(sent[i], b);
		end
		spi_xfer(8'hff, b);
		spi_xfer(8'hff, b);
		wait_byte(b);
		check("data response", data_resp_ok, {3'd0, b[4:0]});
		do
			spi_xfer(8'hff, b);
		while (b == 8'h00);
		check("end of busy", 8'hff, b);
		check("ack low after busy", 1'b0, sector_ack);
		check("write lba", exp_lba, ctrl_lba);
		for (int i = 0; i < sector_bytes; i++)
			check("controller write data", sent[i], got[i]);
	endtask

	initial begin
		logic [7:0]  r1;
		logic [7:0]  cfg;
		logic [31:0] ext;
		logic [31:0] arg;
		logic        sdhc_exp;

		void'($urandom(51));
		buffer_dout_strobe = 1'b0;
		io_ack             = 1'b1;
		sd_cs              = 1'b1;
		sd_sck             = 1'b0;
		sd_sdi             = 1'b1;
		sector_ack         = 1'b0;
		sector_din         = 8'd0;
		sector_din_strobe  = 1'b0;
		sector_dout_strobe = 1'b0;
		allow_sdhc         = 1'b0;
		cycles             = 0;
		repeat (2) @(posedge buffer_dout_strobe);
		io_ack <= 1'b0;
		repeat (4) @(posedge buffer_dout_strobe);
		sd_cs <= 1'b0;
		repeat (4) @(posedge buffer_dout_strobe);

		// card not yet reset
		send_cmd(cmd_read_ocr, 32'd0, r1);
		check("cmd58 before reset", r1_illegal, r1);
		send_cmd(cmd_go_idle, 32'd0, r1);
		check("cmd0 reply", r1_idle, r1);
		send_cmd(cmd_app, 32'd0, r1);
		check("cmd55 reply", r1_idle, r1);
		send_cmd(cmd_app_op_cond, 32'h4000_0000, r1);
		check("acmd41 reply", r1_ok, r1);
		send_cmd(cmd_send_if_cond, 32'h0000_01aa, r1);
		check("cmd8 reply", r1_idle, r1);
		read_ext(ext);
		check("cmd8 echo", 32'h0000_01aa, ext);

		// configuration upload, bit 0 kept set so both addressing modes occur
		@(negedge buffer_dout_strobe);
		check("io_conf before upload", 1'b1, io_conf);
		cfg = 8'($urandom) | 8'h01;
		@(posedge buffer_dout_strobe);
		sector_din        <= cfg;
		sector_din_strobe <= 1'b1;
		@(posedge buffer_dout_strobe);
		sector_din_strobe <= 1'b0;
		repeat (2) @(negedge buffer_dout_strobe);
		check("io_conf after upload", 1'b0, io_conf);

		send_cmd(cmd_set_blocklen, 32'd512, r1);
		check("cmd16 512", r1_ok, r1);
		do
			arg = $urandom;
		while (arg == 32'd512);
		send_cmd(cmd_set_blocklen, arg, r1);
		check("cmd16 other", r1_param_err, r1);

		for (int a = 0; a < 2; a++) begin
			@(posedge buffer_dout_strobe);
			allow_sdhc <= a[0];
			sdhc_exp = a[0] & cfg[0];
			send_cmd(cmd_read_ocr, 32'd0, r1);
			check("cmd58 reply", r1_ok, r1);
			read_ext(ext);
			check("ocr ccs bit", sdhc_exp, ext[30]);
			check("io_sdhc", sdhc_exp, io_sdhc);

			arg = $urandom;
			read_block(arg, sdhc_exp ? arg : arg >> 9, 1'b0);
			arg = $urandom;
			write_block(arg, sdhc_exp ? arg : arg >> 9);
			read_block(arg, sdhc_exp ? arg : arg >> 9, 1'b1);
		end

		$display("Test OK");
		$finish;
	end

endmodule

// File: sd_card_top.f
sd_card_pkg.sv
sd_byte_if.sv
sd_buf_if.sv
sd_spi_link.sv
sd_cmd_decoder.sv
sd_sector_buffer.sv
sd_card_top.sv
sd_card_chk.sv
tb_sd_card.sv

// File: Bender.yml
package:
  name: sd_card

sources:
  - sd_card_pkg.sv
  - sd_byte_if.sv
  - sd_buf_if.sv
  - sd_spi_link.sv
  - sd_cmd_decoder.sv
  - sd_sector_buffer.sv
  - sd_card_top.sv
  - target: test
    files:
      - sd_card_chk.sv
      - tb_sd_card.sv
